/* sim.f */
rtl/adapter_pkg.sv
rtl/write_engine.sv
rtl/read_engine.sv
rtl/axi_adapter.sv
tests/axi_mem_model.sv
tests/axi_adapter_sva.sv
tests/tb_axi_adapter.sv

/* run.sh */
#!/bin/sh
# build and run the adapter regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_axi_adapter \
  --Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vtb_axi_adapter > sim.log 2>&1 \
  || echo "build or simulation error, see build.log" >> sim.log

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || grep -q "Regression passed" sim.log || exit 1

/* tests/tb_axi_adapter.sv */
// testbench for the bus adapter
// clock, reset, random requests, shadow memory and checks
`timescale 1ns/1ns
`default_nettype none

module tb_axi_adapter;

  localparam int unsigned LW = 4;
  // 40 transactions of up to about 60 stalled cycles plus margin
  localparam int MAX_CYCLES = 4000;

  logic clk, rst, req, we, started;
  adapter_pkg::client_req_t                  req_info;
  logic [LW-1:0][adapter_pkg::DATA_W-1:0]    wdata, rdata;
  logic [LW-1:0][adapter_pkg::STRB_W-1:0]    be;
  logic gnt, valid, busy, cw_valid;
  logic [adapter_pkg::ID_W-1:0]   id;
  logic [adapter_pkg::DATA_W-1:0] cw;
  adapter_pkg::aw_chan_t aw;
  adapter_pkg::w_chan_t  w;
  adapter_pkg::b_chan_t  b;
  adapter_pkg::ar_chan_t ar;
  adapter_pkg::r_chan_t  r;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready;
  logic [adapter_pkg::DATA_W-1:0] shadow [64];
  integer seed;
  int     cycles = 0;

  axi_adapter #(.LINE_WORDS(LW)) dut (
    .clk_i(clk), .rst_i(rst), .req_i(req), .we_i(we), .req_info_i(req_info),
    .wdata_i(wdata), .be_i(be), .gnt_o(gnt), .valid_o(valid), .busy_o(busy),
    .id_o(id), .rdata_o(rdata), .critical_word_o(cw), .critical_word_valid_o(cw_valid),
    .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
    .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
    .b_i(b), .b_valid_i(b_valid), .b_ready_o(b_ready),
    .ar_o(ar), .ar_valid_o(ar_valid), .ar_ready_i(ar_ready),
    .r_i(r), .r_valid_i(r_valid), .r_ready_o(r_ready)
  );

  axi_mem_model u_mem (
    .clk_i(clk), .rst_i(rst),
    .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
    .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
    .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready),
    .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
    .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready)
  );

  always #20 clk = ~clk;

  task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
    $display("Regression failed");
    $fatal(1, "value mismatch");
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------------------------------------
  // bus-side checks
  // ----------------------------------------------------------------------
  a_idle: assert property (@(posedge clk) disable iff (rst) !started |->
    !(aw_valid || w_valid || ar_valid || b_ready || r_ready || gnt || valid
      || cw_valid || busy))
    else fail_value("idle outputs", 64'd0, 64'd1);
  a_aw_len: assert property (@(posedge clk) disable iff (rst) aw_valid |->
    aw.len == ((req_info.kind == adapter_pkg::LINE_REQ) ? 8'(LW - 1) : 8'd0))
    else fail_value("aw_o.len",
                    64'((req_info.kind == adapter_pkg::LINE_REQ) ? LW - 1 : 0), 64'(aw.len));
  a_ar_len: assert property (@(posedge clk) disable iff (rst) ar_valid |->
    ar.len == ((req_info.kind == adapter_pkg::LINE_REQ) ? 8'(LW - 1) : 8'd0))
    else fail_value("ar_o.len",
                    64'((req_info.kind == adapter_pkg::LINE_REQ) ? LW - 1 : 0), 64'(ar.len));
  a_ar_align: assert property (@(posedge clk) disable iff (rst)
    ar_valid && req_info.kind == adapter_pkg::LINE_REQ |-> (ar.addr & 32'(LW * 8 - 1)) == 0)
    else fail_value("ar_o.addr", 64'(ar.addr & ~32'(LW * 8 - 1)), 64'(ar.addr));

  // drive one request, wait for its grant, then drop it
  task automatic send_request(input logic wr, input logic line, input logic [5:0] widx,
                              input logic [3:0] rid);
    logic [31:0] rnd;
    @(negedge clk);
    started         = 1'b1;
    req             = 1'b1;
    we              = wr;
    req_info.addr   = {23'd0, widx, 3'd0};
    req_info.kind   = line ? adapter_pkg::LINE_REQ : adapter_pkg::SINGLE_REQ;
    req_info.size   = 2'd3;
    req_info.id     = rid;
    for (int k = 0; k < LW; k++) begin
      rnd      = $random(seed);
      wdata[k] = {$random(seed), $random(seed)};
      be[k]    = rnd[7:0];
    end
    @(posedge clk);
    while (!gnt) begin
      assert (!valid) else fail_value("valid_o before gnt_o", 64'd0, 64'd1);
      @(posedge clk);
    end
    // shadow memory follows every write grant
    if (wr) begin
      for (int k = 0; k < (line ? LW : 1); k++) begin
        for (int b = 0; b < 8; b++) begin
          if (be[k][b]) shadow[6'(widx + 6'(k))][8*b +: 8] = wdata[k][8*b +: 8];
        end
      end
    end
    @(negedge clk);
    req = 1'b0;
  endtask

  task automatic run_request(input logic wr, input logic line, input logic [5:0] widx,
                             input logic [3:0] rid);
    int          cw_count;
    logic [5:0]  base;
    cw_count = 0;
    base     = widx & ~6'(LW - 1);
    send_request(wr, line, widx, rid);
    @(posedge clk);
    while (!valid) begin
      assert (!gnt) else fail_value("second gnt_o", 64'd0, 64'd1);
      if (cw_valid) begin
        cw_count = cw_count + 1;
        assert (cw == shadow[widx]) else fail_value("critical_word_o", shadow[widx], cw);
      end
      @(posedge clk);
    end
    assert (id == rid) else fail_value("id_o", 64'(rid), 64'(id));
    if (!wr) begin
      assert (cw_count == (line ? 1 : 0))
        else fail_value("critical_word_valid_o pulses", 64'(line), 64'(cw_count));
      for (int k = 0; k < (line ? LW : 1); k++) begin
        assert (rdata[k] == shadow[line ? 6'(base + 6'(k)) : widx])
          else fail_value("rdata_o", shadow[line ? 6'(base + 6'(k)) : widx], rdata[k]);
      end
    end
    @(posedge clk);
    assert (!busy) else fail_value("busy_o after valid_o", 64'd0, 64'd1);
    assert (!valid) else fail_value("second valid_o", 64'd0, 64'd1);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [5:0]  line_idx;
    int          off;
    seed     = 8;
    clk      = 1'b0;
    rst      = 1'b1;
    started  = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    req_info = '0;
    wdata    = '0;
    be       = '0;
    for (int i = 0; i < 64; i++) begin
      shadow[i] = {26'h2f0c1d3, 6'(i), 26'h1a2b3c4, ~6'(i)};
    end
    repeat (4) @(posedge clk);
    // requests raised inside reset must never be granted
    @(negedge clk);
    req = 1'b1;
    we  = 1'b1;
    @(negedge clk);
    we  = 1'b0;
    @(negedge clk);
    req = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (3) @(posedge clk);
    for (int it = 0; it < 10; it++) begin
      rnd = $random(seed);
      run_request(1'b1, 1'b0, rnd[5:0], rnd[9:6]);
      run_request(1'b0, 1'b0, rnd[5:0], rnd[13:10]);
      line_idx = rnd[19:14] & ~6'(LW - 1);
      run_request(1'b1, 1'b1, line_idx, rnd[23:20]);
      // a nonzero word offset makes the line read unaligned
      off = 1 + int'(rnd[28:24]) % (LW - 1);
      run_request(1'b0, 1'b1, line_idx | 6'(off), rnd[31:28]);
    end
    @(negedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/axi_adapter_sva.sv */
// bus protocol assertions for the adapter, bound to axi_adapter
`timescale 1ns/1ns
`default_nettype none

module axi_adapter_sva #(
  parameter int unsigned LINE_WORDS = 4
) (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  gnt_o,
  input adapter_pkg::aw_chan_t aw_o,
  input logic                  aw_valid_o,
  input logic                  aw_ready_i,
  input adapter_pkg::w_chan_t  w_o,
  input logic                  w_valid_o,
  input logic                  w_ready_i,
  input adapter_pkg::ar_chan_t ar_o,
  input logic                  ar_valid_o,
  input logic                  ar_ready_i
);

  // W beats taken so far in the current write
  int unsigned w_beats;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_beats <= 0;
    end else if (w_valid_o && w_ready_i) begin
      w_beats <= w_o.last ? 0 : w_beats + 1;
    end
  end

  a_aw_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else $error("AW dropped or changed while stalled");
  a_w_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
    else $error("W dropped or changed while stalled");
  a_ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("AR dropped or changed while stalled");
  a_w_last: assert property (@(posedge clk_i) disable iff (rst_i)
    w_valid_o && w_beats == LINE_WORDS - 1 |-> w_o.last)
    else $error("final line beat without last");
  a_no_gnt_in_reset: assert property (@(posedge clk_i) rst_i |-> !gnt_o)
    else $error("grant during reset");

endmodule

bind axi_adapter axi_adapter_sva #(.LINE_WORDS(LINE_WORDS)) u_sva (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .gnt_o      (gnt_o),
  .aw_o       (aw_o),
  .aw_valid_o (aw_valid_o),
  .aw_ready_i (aw_ready_i),
  .w_o        (w_o),
  .w_valid_o  (w_valid_o),
  .w_ready_i  (w_ready_i),
  .ar_o       (ar_o),
  .ar_valid_o (ar_valid_o),
  .ar_ready_i (ar_ready_i)
);

`default_nettype wire

/* tests/axi_mem_model.sv */
// bus-side memory model, 64 words
// accepts AW and W in either order, returns B and R bursts
// readies and response valids stall at random
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  adapter_pkg::aw_chan_t aw_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  adapter_pkg::w_chan_t  w_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output adapter_pkg::b_chan_t  b_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  input  adapter_pkg::ar_chan_t ar_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output adapter_pkg::r_chan_t  r_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i
);

  logic [adapter_pkg::DATA_W-1:0] mem [64];
  adapter_pkg::w_chan_t           wbuf [8];
  adapter_pkg::aw_chan_t          aw_q;
  adapter_pkg::ar_chan_t          ar_q;
  adapter_pkg::w_chan_t           w_q;
  logic                           aw_hs, w_hs, b_hs, ar_hs, r_hs;
  logic                           aw_got, w_done, b_wait, rd_active;
  logic [5:0]                     rd_word, idx;
  logic [7:0]                     rd_left;
  logic [adapter_pkg::ID_W-1:0]   rd_id;
  logic [31:0]                    rnd;
  int                             wcnt;
  integer                         seed = 8;

  // handshakes seen at the rising edge, acted on at the falling edge
  always @(posedge clk_i) begin
    aw_hs <= aw_valid_i & aw_ready_o;
    w_hs  <= w_valid_i & w_ready_o;
    b_hs  <= b_valid_o & b_ready_i;
    ar_hs <= ar_valid_i & ar_ready_o;
    r_hs  <= r_valid_o & r_ready_i;
    aw_q  <= aw_i;
    w_q   <= w_i;
    ar_q  <= ar_i;
  end

  always @(negedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 64; i++) begin
        mem[i] = {26'h2f0c1d3, 6'(i), 26'h1a2b3c4, ~6'(i)};
      end
      {aw_ready_o, w_ready_o, ar_ready_o, b_valid_o, r_valid_o} = '0;
      {aw_got, w_done, b_wait, rd_active} = '0;
      b_o  = '0;
      r_o  = '0;
      wcnt = 0;
    end else begin
      // ------------------------------------------------------------------
      // write side
      // ------------------------------------------------------------------
      if (aw_hs) aw_got = 1'b1;
      if (w_hs) begin
        wbuf[wcnt] = w_q;
        wcnt       = wcnt + 1;
        if (w_q.last) w_done = 1'b1;
      end
      if (b_hs) begin
        b_valid_o = 1'b0;
        b_wait    = 1'b0;
      end
      if (aw_got && w_done) begin
        for (int k = 0; k < wcnt; k++) begin
          idx = aw_q.addr[8:3] + 6'(k);
          for (int b = 0; b < 8; b++) begin
            if (wbuf[k].strb[b]) mem[idx][8*b +: 8] = wbuf[k].data[8*b +: 8];
          end
        end
        b_o    = '{id: aw_q.id, resp: 2'b00};
        b_wait = 1'b1;
        aw_got = 1'b0;
        w_done = 1'b0;
        wcnt   = 0;
      end
      rnd = $random(seed);
      if (b_wait && !b_valid_o && rnd[7:6] != 2'b00) b_valid_o = 1'b1;

      // ------------------------------------------------------------------
      // read side
      // ------------------------------------------------------------------
      if (ar_hs) begin
        rd_active = 1'b1;
        rd_word   = ar_q.addr[8:3];
        rd_left   = ar_q.len;
        rd_id     = ar_q.id;
      end
      if (r_hs) begin
        r_valid_o = 1'b0;
        if (rd_left == 8'd0) begin
          rd_active = 1'b0;
        end else begin
          rd_left = rd_left - 8'd1;
          rd_word = rd_word + 6'd1;
        end
      end
      if (rd_active && !r_valid_o && rnd[9:8] != 2'b00) begin
        r_valid_o = 1'b1;
        r_o = '{data: mem[rd_word], id: rd_id, resp: 2'b00, last: (rd_left == 8'd0)};
      end

      aw_ready_o = !aw_got && !b_wait && (rnd[1:0] != 2'b00);
      w_ready_o  = !w_done && !b_wait && (rnd[3:2] != 2'b00);
      ar_ready_o = !rd_active && (rnd[5:4] != 2'b00);
    end
  end

endmodule

`default_nettype wire

/* rtl/axi_adapter.sv */
// bus adapter top level
// steers client requests to the write or read engine
// and merges grant, result, id and busy
`timescale 1ns/1ns
`default_nettype none

module axi_adapter #(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  // client side
  input  logic                                         req_i,
  input  logic                                         we_i,
  input  adapter_pkg::client_req_t                     req_info_i,
  input  logic [LINE_WORDS-1:0][adapter_pkg::DATA_W-1:0] wdata_i,
  input  logic [LINE_WORDS-1:0][adapter_pkg::STRB_W-1:0] be_i,
  output logic                                         gnt_o,
  output logic                                         valid_o,
  output logic                                         busy_o,
  output logic [adapter_pkg::ID_W-1:0]                 id_o,
  output logic [LINE_WORDS-1:0][adapter_pkg::DATA_W-1:0] rdata_o,
  output logic [adapter_pkg::DATA_W-1:0]               critical_word_o,
  output logic                                         critical_word_valid_o,
  // bus side
  output adapter_pkg::aw_chan_t                        aw_o,
  output logic                                         aw_valid_o,
  input  logic                                         aw_ready_i,
  output adapter_pkg::w_chan_t                         w_o,
  output logic                                         w_valid_o,
  input  logic                                         w_ready_i,
  input  adapter_pkg::b_chan_t                         b_i,
  input  logic                                         b_valid_i,
  output logic                                         b_ready_o,
  output adapter_pkg::ar_chan_t                        ar_o,
  output logic                                         ar_valid_o,
  input  logic                                         ar_ready_i,
  input  adapter_pkg::r_chan_t                         r_i,
  input  logic                                         r_valid_i,
  output logic                                         r_ready_o
);

  logic                         wr_req, wr_gnt, wr_done, wr_busy;
  logic                         rd_req, rd_gnt, rd_done, rd_busy;
  logic [adapter_pkg::ID_W-1:0] wr_id, rd_id;

  // direction split
  assign wr_req = req_i & we_i;
  assign rd_req = req_i & ~we_i;

  write_engine #(
    .LINE_WORDS (LINE_WORDS)
  ) u_write (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_req_i   (wr_req),
    .req_info_i (req_info_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .gnt_o      (wr_gnt),
    .done_o     (wr_done),
    .busy_o     (wr_busy),
    .id_o       (wr_id),
    .aw_o       (aw_o),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .w_o        (w_o),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .b_i        (b_i),
    .b_valid_i  (b_valid_i),
    .b_ready_o  (b_ready_o)
  );

  read_engine #(
    .LINE_WORDS (LINE_WORDS)
  ) u_read (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .rd_req_i              (rd_req),
    .req_info_i            (req_info_i),
    .gnt_o                 (rd_gnt),
    .done_o                (rd_done),
    .busy_o                (rd_busy),
    .id_o                  (rd_id),
    .rdata_o               (rdata_o),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o),
    .ar_o                  (ar_o),
    .ar_valid_o            (ar_valid_o),
    .ar_ready_i            (ar_ready_i),
    .r_i                   (r_i),
    .r_valid_i             (r_valid_i),
    .r_ready_o             (r_ready_o)
  );

  // ----------------------------------------------------------------------
  // merge, only one engine is active at a time
  // ----------------------------------------------------------------------
  assign gnt_o   = wr_gnt | rd_gnt;
  assign valid_o = wr_done | rd_done;
  assign id_o    = wr_done ? wr_id : rd_id;
  assign busy_o  = wr_busy | rd_busy;

endmodule

`default_nettype wire

/* rtl/read_engine.sv */
// read engine
// single and line reads over AR and R, line buffer
// and critical word detection
`timescale 1ns/1ns
`default_nettype none

module read_engine #(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         rd_req_i,
  input  adapter_pkg::client_req_t                     req_info_i,
  output logic                                         gnt_o,
  output logic                                         done_o,
  output logic                                         busy_o,
  output logic [adapter_pkg::ID_W-1:0]                 id_o,
  output logic [LINE_WORDS-1:0][adapter_pkg::DATA_W-1:0] rdata_o,
  output logic [adapter_pkg::DATA_W-1:0]               critical_word_o,
  output logic                                         critical_word_valid_o,
  output adapter_pkg::ar_chan_t                        ar_o,
  output logic                                         ar_valid_o,
  input  logic                                         ar_ready_i,
  input  adapter_pkg::r_chan_t                         r_i,
  input  logic                                         r_valid_i,
  output logic                                         r_ready_o
);

  localparam int unsigned IDX_W     = $clog2(LINE_WORDS);
  localparam logic [7:0]  BURST_LEN = 8'(LINE_WORDS - 1);
  // byte offset bits of a whole line
  localparam int unsigned LINE_OFF  = adapter_pkg::WORD_OFFSET + IDX_W;

  adapter_pkg::rd_state_e                   state_q, state_d;
  // beat index, stays 0 for a single read
  logic [IDX_W-1:0]                         cnt_q, cnt_d;
  logic [LINE_WORDS-1:0][adapter_pkg::DATA_W-1:0] line_q;
  logic [IDX_W-1:0]                         off_q;
  logic [adapter_pkg::ID_W-1:0]             id_q;
  logic                                     is_line;
  logic                                     beat_ok;
  logic [IDX_W-1:0]                         req_off;
  logic [adapter_pkg::ADDR_W-1:0]           line_addr;

  assign is_line   = (req_info_i.kind == adapter_pkg::LINE_REQ);
  assign req_off   = req_info_i.addr[adapter_pkg::WORD_OFFSET +: IDX_W];
  assign line_addr = {req_info_i.addr[adapter_pkg::ADDR_W-1:LINE_OFF], {LINE_OFF{1'b0}}};
  assign beat_ok   = r_valid_i & r_ready_o;
  assign busy_o    = (state_q != adapter_pkg::RD_IDLE);
  assign rdata_o   = line_q;
  assign id_o      = id_q;

  always_comb begin
    ar_valid_o            = 1'b0;
    ar_o.addr             = is_line ? line_addr : req_info_i.addr;
    ar_o.len              = is_line ? BURST_LEN : 8'd0;
    ar_o.size             = {1'b0, req_info_i.size};
    ar_o.id               = req_info_i.id;
    r_ready_o             = 1'b0;
    gnt_o                 = 1'b0;
    done_o                = 1'b0;
    critical_word_o       = r_i.data;
    critical_word_valid_o = 1'b0;
    state_d               = state_q;
    cnt_d                 = cnt_q;

    case (state_q)
      adapter_pkg::RD_IDLE: begin
        if (rd_req_i) begin
          ar_valid_o = 1'b1;
          gnt_o      = ar_ready_i;
          if (ar_ready_i) begin
            state_d = is_line ? adapter_pkg::RD_WAIT_R_VALID_MULTIPLE
                              : adapter_pkg::RD_WAIT_R_VALID;
          end
        end
      end

      adapter_pkg::RD_WAIT_R_VALID,
      adapter_pkg::RD_WAIT_R_VALID_MULTIPLE: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          // beat index matches the requested word
          if (state_q == adapter_pkg::RD_WAIT_R_VALID_MULTIPLE && cnt_q == off_q) begin
            critical_word_valid_o = 1'b1;
          end
          if (r_i.last) begin
            cnt_d   = '0;
            state_d = adapter_pkg::RD_COMPLETE_READ;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end

      adapter_pkg::RD_COMPLETE_READ: begin
        done_o  = 1'b1;
        state_d = adapter_pkg::RD_IDLE;
      end

      default: state_d = adapter_pkg::RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= adapter_pkg::RD_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // ----------------------------------------------------------------------
  // line buffer, word offset and last beat id
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (beat_ok) begin
      line_q[cnt_q] <= r_i.data;
      if (r_i.last) begin
        id_q <= r_i.id;
      end
    end
    if (gnt_o) begin
      off_q <= req_off;
    end
  end

endmodule

`default_nettype wire

/* rtl/write_engine.sv */
// write engine
// single and line writes over the AW, W and B channels
`timescale 1ns/1ns
`default_nettype none

module write_engine #(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         wr_req_i,
  input  adapter_pkg::client_req_t                     req_info_i,
  input  logic [LINE_WORDS-1:0][adapter_pkg::DATA_W-1:0] wdata_i,
  input  logic [LINE_WORDS-1:0][adapter_pkg::STRB_W-1:0] be_i,
  output logic                                         gnt_o,
  output logic                                         done_o,
  output logic                                         busy_o,
  output logic [adapter_pkg::ID_W-1:0]                 id_o,
  output adapter_pkg::aw_chan_t                        aw_o,
  output logic                                         aw_valid_o,
  input  logic                                         aw_ready_i,
  output adapter_pkg::w_chan_t                         w_o,
  output logic                                         w_valid_o,
  input  logic                                         w_ready_i,
  input  adapter_pkg::b_chan_t                         b_i,
  input  logic                                         b_valid_i,
  output logic                                         b_ready_o
);

  localparam int unsigned         IDX_W     = $clog2(LINE_WORDS);
  localparam logic [7:0]          BURST_LEN = 8'(LINE_WORDS - 1);
  localparam logic [IDX_W-1:0]    LAST_IDX  = IDX_W'(LINE_WORDS - 1);

  adapter_pkg::wr_state_e state_q, state_d;
  // index of the W beat currently offered
  logic [IDX_W-1:0]       cnt_q, cnt_d;
  logic                   is_line;
  logic                   is_last;

  assign is_line = (req_info_i.kind == adapter_pkg::LINE_REQ);
  // a single write has only one beat
  assign is_last = !is_line || (cnt_q == LAST_IDX);
  assign busy_o  = (state_q != adapter_pkg::WR_IDLE);
  assign id_o    = b_i.id;

  always_comb begin
    aw_valid_o = 1'b0;
    aw_o.addr  = req_info_i.addr;
    aw_o.len   = is_line ? BURST_LEN : 8'd0;
    aw_o.size  = {1'b0, req_info_i.size};
    aw_o.id    = req_info_i.id;

    w_valid_o  = 1'b0;
    w_o.data   = is_line ? wdata_i[cnt_q] : wdata_i[0];
    w_o.strb   = is_line ? be_i[cnt_q] : be_i[0];
    w_o.last   = is_last;

    b_ready_o  = 1'b0;
    gnt_o      = 1'b0;
    done_o     = 1'b0;
    state_d    = state_q;
    cnt_d      = cnt_q;

    case (state_q)
      adapter_pkg::WR_IDLE: begin
        if (wr_req_i) begin
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          if (!is_line) begin
            gnt_o = aw_ready_i & w_ready_i;
            case ({aw_ready_i, w_ready_i})
              2'b11:   state_d = adapter_pkg::WR_WAIT_B_VALID;
              2'b01:   state_d = adapter_pkg::WR_WAIT_AW_READY;
              2'b10:   state_d = adapter_pkg::WR_WAIT_LAST_W_READY;
              default: state_d = adapter_pkg::WR_IDLE;
            endcase
          end else begin
            // first beat of the line went out
            if (w_ready_i) begin
              cnt_d = cnt_q + 1'b1;
            end
            case ({aw_ready_i, w_ready_i})
              2'b11:   state_d = adapter_pkg::WR_WAIT_LAST_W_READY;
              2'b01:   state_d = adapter_pkg::WR_WAIT_LAST_W_READY_AW_READY;
              2'b10:   state_d = adapter_pkg::WR_WAIT_LAST_W_READY;
              default: state_d = adapter_pkg::WR_IDLE;
            endcase
          end
        end
      end

      // single write, data taken, address pending
      adapter_pkg::WR_WAIT_AW_READY: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          gnt_o   = 1'b1;
          state_d = adapter_pkg::WR_WAIT_B_VALID;
        end
      end

      // line write with address and data beats both outstanding
      adapter_pkg::WR_WAIT_LAST_W_READY_AW_READY: begin
        aw_valid_o = 1'b1;
        w_valid_o  = 1'b1;
        case ({aw_ready_i, w_ready_i})
          2'b01: begin
            if (is_last) begin
              state_d = adapter_pkg::WR_WAIT_AW_READY_BURST;
            end else begin
              cnt_d = cnt_q + 1'b1;
            end
          end
          2'b10: state_d = adapter_pkg::WR_WAIT_LAST_W_READY;
          2'b11: begin
            if (is_last) begin
              gnt_o   = 1'b1;
              state_d = adapter_pkg::WR_WAIT_B_VALID;
            end else begin
              cnt_d   = cnt_q + 1'b1;
              state_d = adapter_pkg::WR_WAIT_LAST_W_READY;
            end
          end
          default: state_d = state_q;
        endcase
      end

      // every data beat is gone, only AW left
      adapter_pkg::WR_WAIT_AW_READY_BURST: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          gnt_o   = 1'b1;
          state_d = adapter_pkg::WR_WAIT_B_VALID;
        end
      end

      adapter_pkg::WR_WAIT_LAST_W_READY: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          if (is_last) begin
            gnt_o   = 1'b1;
            state_d = adapter_pkg::WR_WAIT_B_VALID;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end

      adapter_pkg::WR_WAIT_B_VALID: begin
        cnt_d = '0;
        if (b_valid_i) begin
          b_ready_o = 1'b1;
          done_o    = 1'b1;
          state_d   = adapter_pkg::WR_IDLE;
        end
      end

      default: state_d = adapter_pkg::WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= adapter_pkg::WR_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/adapter_pkg.sv */
// bus adapter package
// widths, request kind and FSM state enums
// client request and bus channel structs
`default_nettype none

package adapter_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int unsigned DATA_W      = 64;
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned ID_W        = 4;
  localparam int unsigned STRB_W      = DATA_W / 8;
  // byte offset bits inside one bus word
  localparam int unsigned WORD_OFFSET = 3;

  // ----------------------------------------------------------------------
  // enums
  // ----------------------------------------------------------------------
  typedef enum logic {
    SINGLE_REQ,
    LINE_REQ
  } req_kind_e;

  // write FSM, the burst states cover a line write with AW still pending
  typedef enum logic [2:0] {
    WR_IDLE,
    WR_WAIT_AW_READY,
    WR_WAIT_LAST_W_READY,
    WR_WAIT_LAST_W_READY_AW_READY,
    WR_WAIT_AW_READY_BURST,
    WR_WAIT_B_VALID
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT_R_VALID,
    RD_WAIT_R_VALID_MULTIPLE,
    RD_COMPLETE_READ
  } rd_state_e;

  // ----------------------------------------------------------------------
  // client side and bus channels
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    req_kind_e         kind;
    // log2 of the access size in bytes
    logic [1:0]        size;
    logic [ID_W-1:0]   id;
  } client_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [ID_W-1:0]   id;
  } aw_chan_t;

  // read address carries the same fields as write address
  typedef aw_chan_t ar_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    logic [1:0]        resp;
    logic              last;
  } r_chan_t;

endpackage

`default_nettype wire
